// File: design/alu_execute.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_config.svh"

module alu_execute
    import exec_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         cmd_req,
    output logic         cmd_ack,
    input  exec_cmd_t    cmd,
    output logic         res_req,
    input  logic         res_ack,
    output exec_result_t res
);

    localparam int XLEN   = `EXEC_XLEN;
    localparam int WORD_W = 1 << `EXEC_SHAMT_W32;

    typedef enum logic [1:0] {
        S_IDLE,
        S_PEND,
        S_ACK_LOW
    } state_e;

    state_e                  state;
    logic [XLEN-1:0]         a;
    logic [XLEN-1:0]         b;
    logic [`EXEC_SHAMT_W-1:0] shamt;
    logic [WORD_W-1:0]       word_res;
    logic [XLEN-1:0]         pc_rel;
    logic [XLEN-1:0]         link;
    logic [XLEN-1:0]         jalr_sum;
    logic [XLEN-1:0]         value;
    logic [XLEN-1:0]         jump_target;
    logic                    taken;
    logic                    wr_rd;
    logic                    known;
    exec_result_t            next_res;
    logic                    accept;

    assign a        = cmd.operand_a;
    assign b        = cmd.operand_b;
    assign shamt    = b[`EXEC_SHAMT_W-1:0];
    assign word_res = (cmd.op == SUBW) ? a[WORD_W-1:0] - b[WORD_W-1:0]
                                       : a[WORD_W-1:0] + b[WORD_W-1:0];
    assign pc_rel   = cmd.pc + cmd.imm;
    assign link     = cmd.pc + XLEN'(`EXEC_PC_STEP);
    assign jalr_sum = a + cmd.imm;

    always_comb
    begin
        known       = 1'b1;
        wr_rd       = 1'b1;
        taken       = 1'b0;
        value       = '0;
        jump_target = pc_rel;
        case (cmd.op)
            ADD, ADDI:   value = a + b;
            SUB:         value = a - b;
            AND, ANDI:   value = a & b;
            OR, ORI:     value = a | b;
            XOR, XORI:   value = a ^ b;
            SLL, SLLI:   value = a << shamt;
            SRL, SRLI:   value = a >> shamt;
            SRA, SRAI:   value = $signed(a) >>> shamt;
            SLT, SLTI:   value = XLEN'($signed(a) < $signed(b));
            SLTU, SLTIU: value = XLEN'(a < b);
            // Word forms sign-extend bit 31
            ADDW, SUBW, ADDIW: value = {{(XLEN - WORD_W){word_res[WORD_W-1]}}, word_res};
            LUI:         value = cmd.imm;
            AUIPC:       value = pc_rel;
            BEQ, BNE, BLT, BGE, BLTU, BGEU:
            begin
                wr_rd = 1'b0;
                case (cmd.op)
                    BEQ:     taken = (a == b);
                    BNE:     taken = (a != b);
                    BLT:     taken = ($signed(a) < $signed(b));
                    BGE:     taken = ($signed(a) >= $signed(b));
                    BLTU:    taken = (a < b);
                    default: taken = (a >= b);
                endcase
            end
            JAL:
            begin
                value = link;
                taken = 1'b1;
            end
            JALR:
            begin
                value       = link;
                taken       = 1'b1;
                jump_target = {jalr_sum[XLEN-1:1], 1'b0};
            end
            default:
            begin
                known = 1'b0;
                wr_rd = 1'b0;
            end
        endcase
    end

    assign next_res = '{result:       value,
                        rd:           known ? cmd.rd : '0,
                        write_rd:     wr_rd,
                        branch_taken: taken,
                        target:       taken ? jump_target : '0};

    assign accept = (state == S_IDLE) && cmd_req && !cmd_ack;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= S_IDLE;
            cmd_ack <= 1'b0;
            res_req <= 1'b0;
        end
        else
        begin
            if (accept)
                cmd_ack <= 1'b1;
            else if (cmd_ack && !cmd_req)
                cmd_ack <= 1'b0;

            case (state)
                S_IDLE:
                begin
                    if (accept)
                        state <= S_PEND;
                end
                S_PEND:
                begin
                    if (!res_req && !res_ack)
                        res_req <= 1'b1;
                    else if (res_req && res_ack)
                    begin
                        res_req <= 1'b0;
                        state   <= S_ACK_LOW;
                    end
                end
                default:
                begin
                    // Result handshake ends when the ack drops
                    if (!res_ack)
                        state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            res <= next_res;
    end

    a_req_after_ack_low: assert property (@(posedge clk) disable iff (reset)
        (!res_req && res_ack) |=> !res_req)
        else $error("res_req rose while res_ack was still high");

endmodule

`default_nettype wire

// File: design/cmd_accept.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_config.svh"

module cmd_accept
    import exec_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_req,
    output logic                     in_ack,
    input  alu_op_e                  op,
    input  logic [`EXEC_REGNO_W-1:0] rs1_regno,
    input  logic [`EXEC_REGNO_W-1:0] rs2_regno,
    input  logic [`EXEC_XLEN-1:0]    rs1_value,
    input  logic [`EXEC_XLEN-1:0]    rs2_value,
    input  logic [`EXEC_XLEN-1:0]    imm,
    input  logic [`EXEC_XLEN-1:0]    pc,
    input  logic [`EXEC_REGNO_W-1:0] rd,
    output logic                     cmd_req,
    input  logic                     cmd_ack,
    output exec_cmd_t                cmd
);

    logic [`EXEC_XLEN-1:0] opa;
    logic [`EXEC_XLEN-1:0] rs2_resolved;
    logic [`EXEC_XLEN-1:0] opb;
    logic                  take;

    // x0 always reads as zero
    assign opa          = (rs1_regno == '0) ? '0 : rs1_value;
    assign rs2_resolved = (rs2_regno == '0) ? '0 : rs2_value;

    always_comb
    begin
        case (op)
            ADDI, ANDI, ORI, XORI, SLLI, SRLI, SRAI, SLTI, SLTIU, ADDIW: opb = imm;
            default: opb = rs2_resolved;
        endcase
    end

    // Accept only when the previous top handshake and the downstream channel are idle
    assign take = in_req && !in_ack && !cmd_req && !cmd_ack;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            in_ack  <= 1'b0;
            cmd_req <= 1'b0;
        end
        else
        begin
            if (take)
                in_ack <= 1'b1;
            else if (!in_req && in_ack)
                in_ack <= 1'b0;

            if (take)
                cmd_req <= 1'b1;
            else if (cmd_req && cmd_ack)
                cmd_req <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
            cmd <= '{op: op, operand_a: opa, operand_b: opb, imm: imm, pc: pc, rd: rd};
    end

    a_cmd_stable: assert property (@(posedge clk) disable iff (reset)
        (cmd_req && !cmd_ack) |=> $stable(cmd))
        else $error("cmd changed while cmd_req waits for ack");

endmodule

`default_nettype wire

// File: design/exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Data and address width
`define EXEC_XLEN 64
// Instruction size that the link value adds to pc
`define EXEC_PC_STEP 4
`define EXEC_FIFO_DEPTH 4
// Shift amount bits for full-width and word forms
`define EXEC_SHAMT_W 6
`define EXEC_SHAMT_W32 5
`define EXEC_REGNO_W 5

`endif

// File: design/exec_pkg.sv
`default_nettype none

`include "exec_config.svh"

package exec_pkg;

    // Register forms first, then immediate forms, then upper, branch and jump
    typedef enum logic [4:0] {
        ADD, SUB, AND, OR, XOR,
        SLL, SRL, SRA,
        SLT, SLTU,
        ADDW, SUBW,
        ADDI, ANDI, ORI, XORI,
        SLLI, SRLI, SRAI,
        SLTI, SLTIU,
        ADDIW,
        LUI, AUIPC,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        JAL, JALR
    } alu_op_e;

    // Operands are already resolved by the zero-register rule
    typedef struct packed {
        alu_op_e                  op;
        logic [`EXEC_XLEN-1:0]    operand_a;
        logic [`EXEC_XLEN-1:0]    operand_b;
        logic [`EXEC_XLEN-1:0]    imm;
        logic [`EXEC_XLEN-1:0]    pc;
        logic [`EXEC_REGNO_W-1:0] rd;
    } exec_cmd_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]    result;
        logic [`EXEC_REGNO_W-1:0] rd;
        logic                     write_rd;
        logic                     branch_taken;
        // Zero when the branch is not taken
        logic [`EXEC_XLEN-1:0]    target;
    } exec_result_t;

endpackage

`default_nettype wire

// File: design/exec_unit_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_config.svh"

module exec_unit_top
    import exec_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_req,
    output logic                     in_ack,
    input  alu_op_e                  op,
    input  logic [`EXEC_REGNO_W-1:0] rs1_regno,
    input  logic [`EXEC_REGNO_W-1:0] rs2_regno,
    input  logic [`EXEC_XLEN-1:0]    rs1_value,
    input  logic [`EXEC_XLEN-1:0]    rs2_value,
    input  logic [`EXEC_XLEN-1:0]    imm,
    input  logic [`EXEC_XLEN-1:0]    pc,
    input  logic [`EXEC_REGNO_W-1:0] rd,
    output logic                     res_req,
    input  logic                     res_ack,
    output logic [`EXEC_XLEN-1:0]    result,
    output logic [`EXEC_REGNO_W-1:0] res_rd,
    output logic                     res_write_rd,
    output logic                     res_branch_taken,
    output logic [`EXEC_XLEN-1:0]    res_target
);

    logic         acc_req;
    logic         acc_ack;
    exec_cmd_t    acc_cmd;
    logic         exe_req;
    logic         exe_ack;
    exec_cmd_t    exe_cmd;
    logic         alu_req;
    logic         alu_ack;
    exec_result_t alu_res;
    exec_result_t out_res;

    cmd_accept u_cmd_accept (
        .clk(clk), .reset(reset), .in_req(in_req), .in_ack(in_ack), .op(op),
        .rs1_regno(rs1_regno), .rs2_regno(rs2_regno), .rs1_value(rs1_value),
        .rs2_value(rs2_value), .imm(imm), .pc(pc), .rd(rd),
        .cmd_req(acc_req), .cmd_ack(acc_ack), .cmd(acc_cmd)
    );

    handshake_fifo #(.DEPTH(`EXEC_FIFO_DEPTH), .T(exec_cmd_t)) u_cmd_fifo (
        .clk(clk), .reset(reset), .wr_req(acc_req), .wr_data(acc_cmd), .wr_ack(acc_ack),
        .rd_req(exe_req), .rd_ack(exe_ack), .rd_data(exe_cmd)
    );

    alu_execute u_alu_execute (
        .clk(clk), .reset(reset), .cmd_req(exe_req), .cmd_ack(exe_ack), .cmd(exe_cmd),
        .res_req(alu_req), .res_ack(alu_ack), .res(alu_res)
    );

    handshake_fifo #(.DEPTH(`EXEC_FIFO_DEPTH), .T(exec_result_t)) u_res_fifo (
        .clk(clk), .reset(reset), .wr_req(alu_req), .wr_data(alu_res), .wr_ack(alu_ack),
        .rd_req(res_req), .rd_ack(res_ack), .rd_data(out_res)
    );

    assign result           = out_res.result;
    assign res_rd           = out_res.rd;
    assign res_write_rd     = out_res.write_rd;
    assign res_branch_taken = out_res.branch_taken;
    assign res_target       = out_res.target;

endmodule

`default_nettype wire

// File: design/handshake_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module handshake_fifo #(
    parameter int  DEPTH = 2,
    parameter type T     = logic
)
(
    input  logic clk,
    input  logic reset,
    input  logic wr_req,
    input  T     wr_data,
    output logic wr_ack,
    output logic rd_req,
    input  logic rd_ack,
    output T     rd_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // Write side is a four-phase receiver, read side a four-phase sender
    assign push = wr_req && !wr_ack && !full;
    assign pop  = rd_req && rd_ack;

    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            wr_ack <= 1'b0;
            rd_req <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ack <= 1'b1;
            else if (!wr_req && wr_ack)
                wr_ack <= 1'b0;

            // Next offer only after the reader has dropped its ack
            if (!rd_req && !rd_ack && !empty)
                rd_req <= 1'b1;
            else if (pop)
                rd_req <= 1'b0;

            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);

            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    a_no_ack_when_full: assert property (@(posedge clk) disable iff (reset)
        (!wr_ack && full) |=> !wr_ack)
        else $error("wr_ack rose while the FIFO was full");

    a_no_req_when_empty: assert property (@(posedge clk) disable iff (reset)
        (!rd_req && empty) |=> !rd_req)
        else $error("rd_req rose while the FIFO was empty");

    a_rd_data_stable: assert property (@(posedge clk) disable iff (reset)
        (rd_req && !rd_ack) |=> $stable(rd_data))
        else $error("rd_data changed while rd_req waits for ack");

endmodule

`default_nettype wire

// File: dv/exec_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_config.svh"

module exec_unit_tb
    import exec_pkg::*;
();

    localparam int TIMEOUT = 1000;
    // Branch operand pairs giving equal, less, greater and negative against positive
    localparam logic [`EXEC_XLEN-1:0] PAIR_A [4] = '{64'd5, 64'd3, 64'd7, '1};
    localparam logic [`EXEC_XLEN-1:0] PAIR_B [4] = '{64'd5, 64'd7, 64'd3, 64'd1};

    typedef struct {
        alu_op_e                  op;
        logic [`EXEC_REGNO_W-1:0] rs1_regno;
        logic [`EXEC_REGNO_W-1:0] rs2_regno;
        logic [`EXEC_XLEN-1:0]    rs1_value;
        logic [`EXEC_XLEN-1:0]    rs2_value;
        logic [`EXEC_XLEN-1:0]    imm;
        logic [`EXEC_XLEN-1:0]    pc;
        logic [`EXEC_REGNO_W-1:0] rd;
    } stim_t;

    logic                     clk;
    logic                     reset;
    logic                     in_req;
    logic                     in_ack;
    alu_op_e                  op;
    logic [`EXEC_REGNO_W-1:0] rs1_regno;
    logic [`EXEC_REGNO_W-1:0] rs2_regno;
    logic [`EXEC_XLEN-1:0]    rs1_value;
    logic [`EXEC_XLEN-1:0]    rs2_value;
    logic [`EXEC_XLEN-1:0]    imm;
    logic [`EXEC_XLEN-1:0]    pc;
    logic [`EXEC_REGNO_W-1:0] rd;
    logic                     res_req;
    logic                     res_ack;
    logic [`EXEC_XLEN-1:0]    result;
    logic [`EXEC_REGNO_W-1:0] res_rd;
    logic                     res_write_rd;
    logic                     res_branch_taken;
    logic [`EXEC_XLEN-1:0]    res_target;

    int    seed = 11;
    int    errors = 0;
    int    checks = 0;
    int    accepted = 0;
    bit    timed_out = 1'b0;
    stim_t stim_q[$];
    stim_t sent_q[$];

    exec_unit_top u_exec_unit_top (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [`EXEC_XLEN-1:0] rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    // Expected result from the instruction semantics
    function automatic exec_result_t exec_model(input stim_t c);
        logic [`EXEC_XLEN-1:0] a;
        logic [`EXEC_XLEN-1:0] b;
        logic [31:0]           w;
        exec_result_t          r;
        a = (c.rs1_regno == 0) ? '0 : c.rs1_value;
        b = (c.rs2_regno == 0) ? '0 : c.rs2_value;
        if (c.op inside {ADDI, ANDI, ORI, XORI, SLLI, SRLI, SRAI, SLTI, SLTIU, ADDIW})
            b = c.imm;
        r = '0;
        r.rd = c.rd;
        r.write_rd = 1'b1;
        w = (c.op == SUBW) ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
        case (c.op)
            ADD, ADDI:         r.result = a + b;
            SUB:               r.result = a - b;
            AND, ANDI:         r.result = a & b;
            OR, ORI:           r.result = a | b;
            XOR, XORI:         r.result = a ^ b;
            SLL, SLLI:         r.result = a << b[`EXEC_SHAMT_W-1:0];
            SRL, SRLI:         r.result = a >> b[`EXEC_SHAMT_W-1:0];
            SRA, SRAI:         r.result = $signed(a) >>> b[`EXEC_SHAMT_W-1:0];
            SLT, SLTI:         r.result = {63'd0, $signed(a) < $signed(b)};
            SLTU, SLTIU:       r.result = {63'd0, a < b};
            ADDW, SUBW, ADDIW: r.result = {{32{w[31]}}, w};
            LUI:               r.result = c.imm;
            AUIPC:             r.result = c.pc + c.imm;
            BEQ:               r.branch_taken = (a == b);
            BNE:               r.branch_taken = (a != b);
            BLT:               r.branch_taken = ($signed(a) < $signed(b));
            BGE:               r.branch_taken = ($signed(a) >= $signed(b));
            BLTU:              r.branch_taken = (a < b);
            BGEU:              r.branch_taken = (a >= b);
            JAL, JALR:         r.branch_taken = 1'b1;
            default:
            begin
                r.rd       = '0;
                r.write_rd = 1'b0;
            end
        endcase
        if (c.op inside {JAL, JALR})
            r.result = c.pc + `EXEC_PC_STEP;
        if (c.op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU})
            r.write_rd = 1'b0;
        if (r.branch_taken)
            r.target = (c.op == JALR) ? ((a + c.imm) & ~64'd1) : c.pc + c.imm;
        return r;
    endfunction

    function automatic void queue_cmd(input alu_op_e o, input int r1, input int r2,
                                      input logic [`EXEC_XLEN-1:0] v1,
                                      input logic [`EXEC_XLEN-1:0] v2,
                                      input logic [`EXEC_XLEN-1:0] i,
                                      input logic [`EXEC_XLEN-1:0] p, input int d);
        stim_q.push_back('{o, r1[`EXEC_REGNO_W-1:0], r2[`EXEC_REGNO_W-1:0], v1, v2, i, p,
                           d[`EXEC_REGNO_W-1:0]});
    endfunction

    function automatic void queue_random(input int op_count);
        queue_cmd(alu_op_e'(rand_below(op_count)), rand_below(32), rand_below(32),
                  rand_word(), rand_word(), rand_word(), rand_word() & ~64'h3,
                  rand_below(32));
    endfunction

    task automatic check_field(input string name, input logic [`EXEC_XLEN-1:0] exp,
                               input logic [`EXEC_XLEN-1:0] got);
        checks++;
        if (exp !== got)
        begin
            errors++;
            $display("MISMATCH %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic wait_in_ack(input logic level);
        int n;
        n = 0;
        while (in_ack !== level && n < TIMEOUT && !timed_out)
        begin
            @(posedge clk);
            n++;
        end
        if (in_ack !== level && !timed_out)
        begin
            timed_out = 1'b1;
            errors++;
            $display("Timeout: in_ack did not go to %0b within %0d cycles", level, TIMEOUT);
        end
    endtask

    task automatic wait_res_req(input logic level);
        int n;
        n = 0;
        while (res_req !== level && n < TIMEOUT && !timed_out)
        begin
            @(posedge clk);
            n++;
        end
        if (res_req !== level && !timed_out)
        begin
            timed_out = 1'b1;
            errors++;
            $display("Timeout: res_req did not go to %0b within %0d cycles", level, TIMEOUT);
        end
    endtask

    task automatic send_commands(input int max_gap);
        stim_t c;
        while (stim_q.size() > 0)
        begin
            c = stim_q.pop_front();
            repeat (rand_below(max_gap + 1)) @(posedge clk);
            @(posedge clk);
            op        <= c.op;
            rs1_regno <= c.rs1_regno;
            rs2_regno <= c.rs2_regno;
            rs1_value <= c.rs1_value;
            rs2_value <= c.rs2_value;
            imm       <= c.imm;
            pc        <= c.pc;
            rd        <= c.rd;
            in_req    <= 1'b1;
            sent_q.push_back(c);
            wait_in_ack(1'b1);
            accepted++;
            in_req <= 1'b0;
            wait_in_ack(1'b0);
        end
    endtask

    // Compares each result against the model in command order
    task automatic receive_results(input int n, input int max_gap);
        stim_t        c;
        exec_result_t exp;
        for (int i = 0; i < n; i++)
        begin
            wait_res_req(1'b1);
            if (timed_out)
                break;
            if (sent_q.size() == 0)
            begin
                errors++;
                $display("A result arrived with no command outstanding");
            end
            else
            begin
                c = sent_q.pop_front();
                exp = exec_model(c);
                check_field("result", exp.result, result);
                check_field("res_rd", exp.rd, res_rd);
                check_field("res_write_rd", exp.write_rd, res_write_rd);
                check_field("res_branch_taken", exp.branch_taken, res_branch_taken);
                check_field("res_target", exp.target, res_target);
            end
            repeat (rand_below(max_gap + 1)) @(posedge clk);
            res_ack <= 1'b1;
            wait_res_req(1'b0);
            res_ack <= 1'b0;
        end
    endtask

    task automatic run_batch(input int gap_in, input int gap_out);
        int n;
        n = stim_q.size();
        fork
            send_commands(gap_in);
            receive_results(n, gap_out);
        join
        if (sent_q.size() != 0)
        begin
            errors++;
            $display("%0d results never arrived", sent_q.size());
            sent_q.delete();
        end
    endtask

    task automatic report_test(input string name, input int mark);
        $display("test %s finished with %0d errors", name, errors - mark);
    endtask

    initial
    begin
        int mark;
        reset     = 1'b1;
        in_req    = 1'b0;
        res_ack   = 1'b0;
        op        = ADD;
        rs1_regno = '0;
        rs2_regno = '0;
        rs1_value = '0;
        rs2_value = '0;
        imm       = '0;
        pc        = '0;
        rd        = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        mark = errors;
        @(posedge clk);
        check_field("in_ack", 0, in_ack);
        check_field("res_req", 0, res_req);
        queue_cmd(ADD, 1, 2, 64'h10, 64'h20, 64'h0, 64'h1000, 3);
        run_batch(0, 0);
        report_test("reset_and_first", mark);

        mark = errors;
        queue_cmd(ADDIW, 1, 0, 64'h7fff_ffff, 64'h0, 64'h1, 64'h2000, 5);
        queue_cmd(ADDW, 1, 2, 64'h1234_5678_ffff_fff0, 64'h20, 64'h0, 64'h2004, 6);
        queue_cmd(SUBW, 1, 2, 64'h0, 64'h1, 64'h0, 64'h2008, 7);
        for (int i = 0; i < 60; i++)
            queue_random(int'(AUIPC) + 1);
        run_batch(0, 0);
        report_test("alu_ops", mark);

        mark = errors;
        for (int k = int'(BEQ); k <= int'(BGEU); k++)
            for (int j = 0; j < 4; j++)
                queue_cmd(alu_op_e'(k), 1, 2, PAIR_A[j], PAIR_B[j], 64'h40, 64'h3000, 8);
        queue_cmd(JAL, 0, 0, 64'h0, 64'h0, -64'sd16, 64'h3100, 1);
        queue_cmd(JALR, 4, 0, 64'h2001, 64'h0, 64'h4, 64'h3200, 1);
        run_batch(0, 0);
        report_test("branches_and_jumps", mark);

        mark = errors;
        queue_cmd(ADD, 0, 2, 64'hdead_beef, 64'h5, 64'h0, 64'h4000, 9);
        queue_cmd(SUB, 3, 0, 64'h9, 64'hffff, 64'h0, 64'h4004, 10);
        queue_cmd(BEQ, 0, 0, 64'h1, 64'h2, 64'h40, 64'h4008, 0);
        queue_cmd(JALR, 0, 1, 64'h1234, 64'h0, 64'h101, 64'h400c, 11);
        run_batch(0, 0);
        report_test("zero_register", mark);

        mark = errors;
        accepted = 0;
        for (int i = 0; i < 12; i++)
            queue_random(int'(JALR) + 1);
        fork
            send_commands(0);
            begin
                repeat (200) @(posedge clk);
                if (accepted >= 12)
                begin
                    errors++;
                    $display("in_ack kept rising while res_ack was held low");
                end
                receive_results(12, 0);
            end
        join
        report_test("back_pressure", mark);

        mark = errors;
        for (int i = 0; i < 200; i++)
            queue_random(int'(JALR) + 1);
        run_batch(3, 3);
        repeat (20)
        begin
            @(posedge clk);
            if (res_req !== 1'b0)
            begin
                errors++;
                $display("An extra result appeared after all commands completed");
            end
        end
        report_test("random_delays", mark);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+design
design/exec_pkg.sv
design/cmd_accept.sv
design/handshake_fifo.sv
design/alu_execute.sv
design/exec_unit_top.sv
dv/exec_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module exec_unit_tb \
    --Mdir obj_dir \
    && ./obj_dir/Vexec_unit_tb | tee /dev/stderr | grep -qx "TEST PASS" \
    || { echo "simulation failed"; exit 1; }
echo "simulation passed"
